// ==== vlog.f ====
+incdir+include
source/core_prof_pkg.sv
source/prof_event_decode.sv
source/perf_counter_bank.sv
source/print_stat_tracker.sv
source/stat_snapshot_unit.sv
source/core_profiler.sv
dv/core_profiler_tb.sv

// ==== dv/core_profiler_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_prof_settings.svh"

module core_profiler_tb;

  localparam int CW = `PROF_COUNT_W;
  localparam int NC = `PROF_NUM_COUNTERS;

  logic        clk_i;
  logic        reset_i;
  logic        stall_i;
  logic        stall_depend_i;
  logic        stall_fp_i;
  logic        stall_ifetch_wait_i;
  logic        stall_icache_store_i;
  logic        stall_lr_aq_i;
  logic        stall_fence_i;
  logic        stall_md_i;
  logic        stall_force_wb_i;
  logic        stall_remote_req_i;
  logic        stall_local_flw_i;
  logic        flush_i;
  logic [31:0] id_instr_i;
  logic        id_icache_miss_i;
  logic        id_is_fp_float_i;
  logic        id_fadd_i;
  logic        id_fmul_i;
  logic        id_is_load_i;
  logic        id_is_store_i;
  logic        id_is_branch_i;
  logic        branch_mispredict_i;
  logic        jalr_mispredict_i;
  logic        remote_req_v_i;
  logic        remote_req_yumi_i;
  logic [31:0] remote_req_addr_i;
  logic [31:0] remote_req_payload_i;
  logic [31:0] global_ctr_i;
  logic        stat_v_o;
  logic [4:0]  stat_idx_o;
  logic [31:0] stat_data_o;
  logic [31:0] stat_tag_o;
  logic [31:0] stat_global_ctr_o;
  logic        stat_last_o;
  logic        busy_o;

  int errors;
  int tests_run;
  int tests_failed;

  core_profiler u_dut (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // The global counter is just a moving value so the capture cycle is visible.
  always @(negedge clk_i) global_ctr_i <= global_ctr_i + 32'd7;

  // ####################################################################
  // Reference model of the counters, the print shadow pipe and the stream.

  logic [CW-1:0]    mcnt [NC];
  logic             m_mem;
  logic             m_wb;
  logic [31:0]      m_tag_mem;
  logic [31:0]      m_tag_wb;
  logic             m_accept;
  logic             m_print;
  logic             exp_v;
  logic [4:0]       exp_idx;
  logic [NC*CW-1:0] frz_bus;
  logic [31:0]      exp_tag;
  logic [CW-1:0]    exp_gctr;
  logic [CW-1:0]    exp_word;

  function automatic logic [`PROF_NUM_EVENTS-1:0] model_events();
    logic [`PROF_NUM_EVENTS-1:0] ev;
    logic                        commit;
    logic                        specific;
    commit = !stall_i && !stall_depend_i && !flush_i && (id_instr_i != 32'd0)
             && !id_icache_miss_i;
    specific = stall_ifetch_wait_i || stall_icache_store_i || stall_lr_aq_i
               || stall_fence_i || stall_md_i || stall_remote_req_i || stall_local_flw_i;
    ev = '0;
    ev[`PROF_EV_INSTR]  = commit;
    ev[`PROF_EV_FADD]   = commit && id_is_fp_float_i && id_fadd_i;
    ev[`PROF_EV_FMUL]   = commit && id_is_fp_float_i && id_fmul_i;
    ev[`PROF_EV_LD]     = commit && id_is_load_i;
    ev[`PROF_EV_ST]     = commit && id_is_store_i;
    ev[`PROF_EV_BRANCH] = commit && (id_is_branch_i || id_instr_i[6:0] == 7'b1100111);
    ev[`PROF_EV_MISPREDICT] = (branch_mispredict_i || jalr_mispredict_i)
                              && !stall_i && !stall_depend_i && !stall_fp_i;
    ev[`PROF_EV_ST_FP]     = stall_fp_i && !stall_i && !stall_depend_i;
    ev[`PROF_EV_ST_DEPEND] = stall_depend_i && !stall_i && !stall_fp_i;
    ev[`PROF_EV_ST_IFETCH]     = stall_ifetch_wait_i;
    ev[`PROF_EV_ST_LR_AQ]      = stall_lr_aq_i;
    ev[`PROF_EV_ST_FENCE]      = stall_fence_i;
    ev[`PROF_EV_ST_MD]         = stall_md_i;
    ev[`PROF_EV_ST_FORCE_WB]   = stall_force_wb_i && !specific;
    ev[`PROF_EV_ST_REMOTE_REQ] = stall_remote_req_i;
    ev[`PROF_EV_ST_LOCAL_FLW]  = stall_local_flw_i;
    return ev;
  endfunction

  assign m_accept = remote_req_v_i && remote_req_yumi_i
                    && (remote_req_addr_i == `PROF_PRINT_STAT_ADDR);
  assign m_print  = m_wb && !stall_i;
  assign exp_word = frz_bus[exp_idx*CW +: CW];

  always @(posedge clk_i) begin : model_update
    logic [`PROF_NUM_EVENTS-1:0] ev;
    ev = model_events();
    if (reset_i) begin
      for (int k = 0; k < NC; k++) mcnt[k] <= '0;
      m_mem   <= 1'b0;
      m_wb    <= 1'b0;
      exp_v   <= 1'b0;
      exp_idx <= '0;
    end else begin
      mcnt[0] <= mcnt[0] + 1;
      for (int k = 0; k < `PROF_NUM_EVENTS; k++) begin
        if (ev[k]) mcnt[k+1] <= mcnt[k+1] + 1;
      end
      if (!stall_i) begin
        m_mem <= m_accept;
        m_wb  <= m_mem;
        if (m_accept) m_tag_mem <= remote_req_payload_i;
        if (m_mem) m_tag_wb <= m_tag_mem;
      end
      if (exp_v) begin
        exp_v   <= (exp_idx != NC - 1);
        exp_idx <= (exp_idx == NC - 1) ? 5'd0 : exp_idx + 5'd1;
      end else if (m_print) begin
        exp_v    <= 1'b1;
        exp_idx  <= '0;
        exp_tag  <= m_tag_wb;
        exp_gctr <= global_ctr_i;
        for (int k = 0; k < NC; k++) frz_bus[k*CW +: CW] <= mcnt[k];
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    errors++;
    $display("Fail %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("Error: %s at %0t", what, $time);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val) else report_mismatch(name, exp_val, act_val);
  endtask

  // ####################################################################
  // Stream checks against the frozen model copy.

  a_valid: assert property (@(posedge clk_i) disable iff (reset_i) stat_v_o == exp_v)
    else report_mismatch("stat_v_o", $sampled(exp_v), $sampled(stat_v_o));
  a_busy: assert property (@(posedge clk_i) disable iff (reset_i) busy_o == exp_v)
    else report_mismatch("busy_o", $sampled(exp_v), $sampled(busy_o));
  a_last: assert property (@(posedge clk_i) disable iff (reset_i)
                           stat_last_o == (exp_v && exp_idx == NC - 1))
    else report_mismatch("stat_last_o", $sampled(exp_v && exp_idx == NC - 1),
                         $sampled(stat_last_o));
  a_idx: assert property (@(posedge clk_i) disable iff (reset_i)
                          stat_v_o |-> stat_idx_o == exp_idx)
    else report_mismatch("stat_idx_o", $sampled(exp_idx), $sampled(stat_idx_o));
  a_data: assert property (@(posedge clk_i) disable iff (reset_i)
                           stat_v_o |-> stat_data_o == exp_word)
    else report_mismatch("stat_data_o", $sampled(exp_word), $sampled(stat_data_o));
  a_tag: assert property (@(posedge clk_i) disable iff (reset_i)
                          stat_v_o |-> stat_tag_o == exp_tag)
    else report_mismatch("stat_tag_o", $sampled(exp_tag), $sampled(stat_tag_o));
  a_gctr: assert property (@(posedge clk_i) disable iff (reset_i)
                           stat_v_o |-> stat_global_ctr_o == exp_gctr)
    else report_mismatch("stat_global_ctr_o", $sampled(exp_gctr),
                         $sampled(stat_global_ctr_o));

  // ####################################################################
  // Stimulus helpers.

  function automatic logic one_in(input int n);
    return ($urandom % n) == 0;
  endfunction

  task automatic clear_inputs();
    {stall_i, stall_depend_i, stall_fp_i, stall_ifetch_wait_i} = '0;
    {stall_icache_store_i, stall_lr_aq_i, stall_fence_i, stall_md_i} = '0;
    {stall_force_wb_i, stall_remote_req_i, stall_local_flw_i, flush_i} = '0;
    {id_icache_miss_i, id_is_fp_float_i, id_fadd_i, id_fmul_i} = '0;
    {id_is_load_i, id_is_store_i, id_is_branch_i} = '0;
    {branch_mispredict_i, jalr_mispredict_i} = '0;
    {remote_req_v_i, remote_req_yumi_i} = '0;
    id_instr_i           = '0;
    remote_req_addr_i    = '0;
    remote_req_payload_i = '0;
  endtask

  task automatic drive_random_decode();
    int pick;
    pick = $urandom % 6;
    if (pick == 0) id_instr_i = 32'd0;
    else if (pick == 1) id_instr_i = {25'($urandom_range(32'h1ff_ffff, 0)), 7'b1100111};
    else id_instr_i = $urandom;
    id_icache_miss_i = one_in(8);
    id_is_fp_float_i = one_in(2);
    id_fadd_i        = one_in(3);
    id_fmul_i        = one_in(3);
    id_is_load_i     = one_in(4);
    id_is_store_i    = one_in(4);
    id_is_branch_i   = one_in(5);
    flush_i          = one_in(8);
  endtask

  task automatic drive_random_stalls(input int n);
    stall_i              = one_in(n);
    stall_depend_i       = one_in(n);
    stall_fp_i           = one_in(n);
    stall_ifetch_wait_i  = one_in(n);
    stall_icache_store_i = one_in(n);
    stall_lr_aq_i        = one_in(n);
    stall_fence_i        = one_in(n);
    stall_md_i           = one_in(n);
    stall_force_wb_i     = one_in(2);
    stall_remote_req_i   = one_in(n);
    stall_local_flw_i    = one_in(n);
    branch_mispredict_i  = one_in(4);
    jalr_mispredict_i    = one_in(6);
  endtask

  // Returns one falling edge after the request cycle.
  task automatic accept_print(input logic [31:0] tag);
    @(negedge clk_i);
    remote_req_v_i       = 1'b1;
    remote_req_yumi_i    = 1'b1;
    remote_req_addr_i    = `PROF_PRINT_STAT_ADDR;
    remote_req_payload_i = tag;
    @(negedge clk_i);
    remote_req_v_i       = 1'b0;
    remote_req_yumi_i    = 1'b0;
    remote_req_addr_i    = '0;
    remote_req_payload_i = '0;
  endtask

  task automatic wait_for_stream(input int limit, output int waited);
    waited = 0;
    while (!stat_v_o && waited < limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!stat_v_o) report_problem("timed out waiting for the stat stream to start");
  endtask

  task automatic wait_for_idle(input int limit);
    int n;
    n = 0;
    while (busy_o && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (busy_o) report_problem("timed out waiting for the stat stream to end");
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      if (stat_v_o || busy_o) report_problem("stream active without an accepted print");
    end
  endtask

  task automatic run_print(input logic [31:0] tag);
    int waited;
    accept_print(tag);
    wait_for_stream(30, waited);
    wait_for_idle(40);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
      $display("Test %s: failed, %0d errors", name, errors - errs_before);
    end else begin
      $display("Test %s: passed", name);
    end
  endtask

  initial begin
    int mark;
    int waited;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(27921));
    clear_inputs();
    global_ctr_i = 32'h0100_0000;
    reset_i      = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    mark = errors;
    expect_quiet(10);
    check_value("stat_last_o", 32'd0, stat_last_o);
    run_print(32'h0000_0011);
    finish_test("1 reset and idle", mark);

    mark = errors;
    repeat (300) begin
      @(negedge clk_i);
      drive_random_decode();
      stall_i        = one_in(4);
      stall_depend_i = one_in(4);
      stall_fp_i     = one_in(4);
    end
    @(negedge clk_i);
    clear_inputs();
    run_print(32'h0000_0022);
    finish_test("2 commit classification", mark);

    mark = errors;
    repeat (300) begin
      @(negedge clk_i);
      drive_random_decode();
      drive_random_stalls(3);
    end
    @(negedge clk_i);
    clear_inputs();
    run_print(32'h0000_0033);
    finish_test("3 stall attribution", mark);

    mark = errors;
    repeat (6) begin
      @(negedge clk_i);
      remote_req_v_i    = 1'b1;
      remote_req_yumi_i = one_in(2);
      remote_req_addr_i = remote_req_yumi_i ? 32'h0000_1000 : `PROF_PRINT_STAT_ADDR;
      remote_req_payload_i = $urandom;
    end
    @(negedge clk_i);
    clear_inputs();
    expect_quiet(8);
    accept_print(32'hCAFE_0044);
    wait_for_stream(30, waited);
    check_value("first stat_v_o latency", 32'd3, waited + 1);
    wait_for_idle(40);
    finish_test("4 print pipeline", mark);

    mark = errors;
    @(negedge clk_i);
    remote_req_v_i       = 1'b1;
    remote_req_yumi_i    = 1'b1;
    remote_req_addr_i    = `PROF_PRINT_STAT_ADDR;
    remote_req_payload_i = 32'h5A11_0055;
    @(negedge clk_i);
    clear_inputs();
    // Hold the print first in the memory stage, then in writeback.
    stall_i = 1'b1;
    expect_quiet(3);
    stall_i = 1'b0;
    @(negedge clk_i);
    stall_i = 1'b1;
    expect_quiet(3);
    stall_i = 1'b0;
    wait_for_stream(30, waited);
    for (int i = 0; i < NC; i++) begin
      check_value("stat_idx_o", i, stat_idx_o);
      check_value("stat_last_o", (i == NC - 1), stat_last_o);
      @(negedge clk_i);
    end
    check_value("stat_v_o", 32'd0, stat_v_o);
    accept_print(32'h0000_0066);
    wait_for_stream(30, waited);
    accept_print(32'h0000_0077);
    wait_for_idle(40);
    expect_quiet(10);
    finish_test("5 stall freeze and stream form", mark);

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/core_profiler.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_profiler (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   stall_i,
  input  wire logic                   stall_depend_i,
  input  wire logic                   stall_fp_i,
  input  wire logic                   stall_ifetch_wait_i,
  input  wire logic                   stall_icache_store_i,
  input  wire logic                   stall_lr_aq_i,
  input  wire logic                   stall_fence_i,
  input  wire logic                   stall_md_i,
  input  wire logic                   stall_force_wb_i,
  input  wire logic                   stall_remote_req_i,
  input  wire logic                   stall_local_flw_i,
  input  wire logic                   flush_i,
  input  wire core_prof_pkg::instr_t  id_instr_i,
  input  wire logic                   id_icache_miss_i,
  input  wire logic                   id_is_fp_float_i,
  input  wire logic                   id_fadd_i,
  input  wire logic                   id_fmul_i,
  input  wire logic                   id_is_load_i,
  input  wire logic                   id_is_store_i,
  input  wire logic                   id_is_branch_i,
  input  wire logic                   branch_mispredict_i,
  input  wire logic                   jalr_mispredict_i,
  input  wire logic                   remote_req_v_i,
  input  wire logic                   remote_req_yumi_i,
  input  wire core_prof_pkg::addr_t   remote_req_addr_i,
  input  wire core_prof_pkg::data_t   remote_req_payload_i,
  input  wire core_prof_pkg::count_t  global_ctr_i,
  output logic                        stat_v_o,
  output core_prof_pkg::stat_idx_t    stat_idx_o,
  output core_prof_pkg::count_t       stat_data_o,
  output core_prof_pkg::data_t        stat_tag_o,
  output core_prof_pkg::count_t       stat_global_ctr_o,
  output logic                        stat_last_o,
  output logic                        busy_o
);

  import core_prof_pkg::*;

  event_vec_t events;
  count_bus_t counters;
  logic       print_now;
  data_t      print_tag;

  prof_event_decode u_event_decode (
    .stall_i              (stall_i),
    .stall_depend_i       (stall_depend_i),
    .stall_fp_i           (stall_fp_i),
    .stall_ifetch_wait_i  (stall_ifetch_wait_i),
    .stall_icache_store_i (stall_icache_store_i),
    .stall_lr_aq_i        (stall_lr_aq_i),
    .stall_fence_i        (stall_fence_i),
    .stall_md_i           (stall_md_i),
    .stall_force_wb_i     (stall_force_wb_i),
    .stall_remote_req_i   (stall_remote_req_i),
    .stall_local_flw_i    (stall_local_flw_i),
    .flush_i              (flush_i),
    .id_instr_i           (id_instr_i),
    .id_icache_miss_i     (id_icache_miss_i),
    .id_is_fp_float_i     (id_is_fp_float_i),
    .id_fadd_i            (id_fadd_i),
    .id_fmul_i            (id_fmul_i),
    .id_is_load_i         (id_is_load_i),
    .id_is_store_i        (id_is_store_i),
    .id_is_branch_i       (id_is_branch_i),
    .branch_mispredict_i  (branch_mispredict_i),
    .jalr_mispredict_i    (jalr_mispredict_i),
    .events_o             (events)
  );

  perf_counter_bank u_counter_bank (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .events_i   (events),
    .counters_o (counters)
  );

  print_stat_tracker u_print_tracker (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .stall_i              (stall_i),
    .remote_req_v_i       (remote_req_v_i),
    .remote_req_yumi_i    (remote_req_yumi_i),
    .remote_req_addr_i    (remote_req_addr_i),
    .remote_req_payload_i (remote_req_payload_i),
    .print_now_o          (print_now),
    .print_tag_o          (print_tag)
  );

  stat_snapshot_unit u_snapshot (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .print_now_i       (print_now),
    .print_tag_i       (print_tag),
    .counters_i        (counters),
    .global_ctr_i      (global_ctr_i),
    .stat_v_o          (stat_v_o),
    .stat_idx_o        (stat_idx_o),
    .stat_data_o       (stat_data_o),
    .stat_tag_o        (stat_tag_o),
    .stat_global_ctr_o (stat_global_ctr_o),
    .stat_last_o       (stat_last_o),
    .busy_o            (busy_o)
  );

endmodule

`default_nettype wire

// ==== source/stat_snapshot_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_prof_settings.svh"

module stat_snapshot_unit (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  input  wire logic                       print_now_i,
  input  wire core_prof_pkg::data_t       print_tag_i,
  input  wire core_prof_pkg::count_bus_t  counters_i,
  input  wire core_prof_pkg::count_t      global_ctr_i,
  output logic                            stat_v_o,
  output core_prof_pkg::stat_idx_t        stat_idx_o,
  output core_prof_pkg::count_t           stat_data_o,
  output core_prof_pkg::data_t            stat_tag_o,
  output core_prof_pkg::count_t           stat_global_ctr_o,
  output logic                            stat_last_o,
  output logic                            busy_o
);

  import core_prof_pkg::*;

  localparam stat_idx_t LastIdx = stat_idx_t'(`PROF_NUM_COUNTERS - 1);

  snap_state_e state_r;
  stat_idx_t   idx_r;
  logic        capture;
  logic        at_last;

  count_bus_t  snap_r;
  data_t       tag_r;
  count_t      gctr_r;

  assign capture = print_now_i & (state_r == SNAP_IDLE);
  assign at_last = (idx_r == LastIdx);

  // ####################################################################
  // Control: idle until a print, then one word per cycle.

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= SNAP_IDLE;
      idx_r   <= '0;
    end else begin
      case (state_r)
        SNAP_IDLE: begin
          if (capture) begin
            state_r <= SNAP_EMIT;
            idx_r   <= '0;
          end
        end
        SNAP_EMIT: begin
          // A print arriving here is ignored; the stream cannot restart.
          if (at_last) begin
            state_r <= SNAP_IDLE;
            idx_r   <= '0;
          end else begin
            idx_r <= idx_r + stat_idx_t'(1);
          end
        end
        default: begin
          state_r <= SNAP_IDLE;
          idx_r   <= '0;
        end
      endcase
    end
  end

  // Snapshot copy of the counters, taken as they stood in the print cycle.
  always_ff @(posedge clk_i) begin
    if (capture) begin
      snap_r <= counters_i;
      tag_r  <= print_tag_i;
      gctr_r <= global_ctr_i;
    end
  end

  // ####################################################################
  // Stream outputs.

  assign stat_v_o          = (state_r == SNAP_EMIT);
  assign stat_last_o       = (state_r == SNAP_EMIT) & at_last;
  assign busy_o            = (state_r == SNAP_EMIT);
  assign stat_idx_o        = idx_r;
  assign stat_data_o       = snap_r[idx_r*`PROF_COUNT_W +: `PROF_COUNT_W];
  assign stat_tag_o        = tag_r;
  assign stat_global_ctr_o = gctr_r;

endmodule

`default_nettype wire

// ==== source/print_stat_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_prof_settings.svh"

module print_stat_tracker (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  stall_i,
  input  wire logic                  remote_req_v_i,
  input  wire logic                  remote_req_yumi_i,
  input  wire core_prof_pkg::addr_t  remote_req_addr_i,
  input  wire core_prof_pkg::data_t  remote_req_payload_i,
  output logic                       print_now_o,
  output core_prof_pkg::data_t       print_tag_o
);

  import core_prof_pkg::*;

  logic  print_exe;
  logic  print_mem_r;
  logic  print_wb_r;
  data_t tag_mem_r;
  data_t tag_wb_r;

  // The store counts as issued once the network has taken it.
  assign print_exe = remote_req_v_i & remote_req_yumi_i
                   & (remote_req_addr_i == addr_t'(`PROF_PRINT_STAT_ADDR));

  // ####################################################################
  // Shadow memory and writeback stages, frozen while the core stalls.

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      print_mem_r <= 1'b0;
      print_wb_r  <= 1'b0;
    end else if (~stall_i) begin
      print_mem_r <= print_exe;
      print_wb_r  <= print_mem_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (~stall_i) begin
      if (print_exe) begin
        tag_mem_r <= remote_req_payload_i;
      end
      if (print_mem_r) begin
        tag_wb_r <= tag_mem_r;
      end
    end
  end

  // Writeback retires only in a cycle where the pipeline moves.
  assign print_now_o = print_wb_r & ~stall_i;
  assign print_tag_o = tag_wb_r;

endmodule

`default_nettype wire

// ==== source/perf_counter_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_prof_settings.svh"

module perf_counter_bank (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,
  input  wire core_prof_pkg::event_vec_t events_i,
  output core_prof_pkg::count_bus_t     counters_o
);

  import core_prof_pkg::*;

  // Index 0 always counts, so the enables are the events shifted up by one.
  logic [`PROF_NUM_COUNTERS-1:0] inc;
  count_t                        cnt_r [`PROF_NUM_COUNTERS];

  assign inc = {events_i, 1'b1};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int k = 0; k < `PROF_NUM_COUNTERS; k++) begin
        cnt_r[k] <= '0;
      end
    end else begin
      for (int k = 0; k < `PROF_NUM_COUNTERS; k++) begin
        if (inc[k]) begin
          cnt_r[k] <= cnt_r[k] + count_t'(1);
        end
      end
    end
  end

  // ####################################################################
  // Pack the counters with index 0 in the low word.

  for (genvar g = 0; g < `PROF_NUM_COUNTERS; g++) begin : g_pack
    assign counters_o[g*`PROF_COUNT_W +: `PROF_COUNT_W] = cnt_r[g];
  end

endmodule

`default_nettype wire

// ==== source/prof_event_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_prof_settings.svh"

module prof_event_decode (
  input  wire logic                      stall_i,
  input  wire logic                      stall_depend_i,
  input  wire logic                      stall_fp_i,
  input  wire logic                      stall_ifetch_wait_i,
  input  wire logic                      stall_icache_store_i,
  input  wire logic                      stall_lr_aq_i,
  input  wire logic                      stall_fence_i,
  input  wire logic                      stall_md_i,
  input  wire logic                      stall_force_wb_i,
  input  wire logic                      stall_remote_req_i,
  input  wire logic                      stall_local_flw_i,
  input  wire logic                      flush_i,
  input  wire core_prof_pkg::instr_t     id_instr_i,
  input  wire logic                      id_icache_miss_i,
  input  wire logic                      id_is_fp_float_i,
  input  wire logic                      id_fadd_i,
  input  wire logic                      id_fmul_i,
  input  wire logic                      id_is_load_i,
  input  wire logic                      id_is_store_i,
  input  wire logic                      id_is_branch_i,
  input  wire logic                      branch_mispredict_i,
  input  wire logic                      jalr_mispredict_i,
  output core_prof_pkg::event_vec_t      events_o
);

  logic       committed;
  logic       is_jalr;
  logic [6:0] opcode;
  logic       other_stall;

  // ####################################################################
  // Commit qualification.
  // An instruction leaves decode when nothing holds it and it is a real,
  // fetched word that is not being flushed.

  assign committed = ~stall_i & ~stall_depend_i & ~flush_i
                   & (id_instr_i != '0)
                   & ~id_icache_miss_i;

  assign opcode  = id_instr_i[6:0];
  assign is_jalr = (opcode == `PROF_JALR_OP);

  // Force-writeback is only blamed when no more specific cause is active.
  assign other_stall = stall_ifetch_wait_i | stall_icache_store_i | stall_lr_aq_i
                     | stall_fence_i | stall_md_i | stall_remote_req_i
                     | stall_local_flw_i;

  always_comb begin
    events_o = '0;

    events_o[`PROF_EV_INSTR]  = committed;
    events_o[`PROF_EV_FADD]   = committed & id_is_fp_float_i & id_fadd_i;
    events_o[`PROF_EV_FMUL]   = committed & id_is_fp_float_i & id_fmul_i;
    events_o[`PROF_EV_LD]     = committed & id_is_load_i;
    events_o[`PROF_EV_ST]     = committed & id_is_store_i;
    events_o[`PROF_EV_BRANCH] = committed & (id_is_branch_i | is_jalr);

    events_o[`PROF_EV_MISPREDICT] = (branch_mispredict_i | jalr_mispredict_i)
                                  & ~(stall_i | stall_depend_i | stall_fp_i);

    // The depend and fp stalls mask each other so a cycle is charged once.
    events_o[`PROF_EV_ST_FP]     = stall_fp_i & ~(stall_i | stall_depend_i);
    events_o[`PROF_EV_ST_DEPEND] = stall_depend_i & ~(stall_i | stall_fp_i);

    events_o[`PROF_EV_ST_IFETCH]     = stall_ifetch_wait_i;
    events_o[`PROF_EV_ST_LR_AQ]      = stall_lr_aq_i;
    events_o[`PROF_EV_ST_FENCE]      = stall_fence_i;
    events_o[`PROF_EV_ST_MD]         = stall_md_i;
    events_o[`PROF_EV_ST_FORCE_WB]   = stall_force_wb_i & ~other_stall;
    events_o[`PROF_EV_ST_REMOTE_REQ] = stall_remote_req_i;
    events_o[`PROF_EV_ST_LOCAL_FLW]  = stall_local_flw_i;
  end

endmodule

`default_nettype wire

// ==== source/core_prof_pkg.sv ====
`default_nettype none

`include "core_prof_settings.svh"

package core_prof_pkg;

  // ####################################################################
  // Shared datapath types.

  typedef logic [`PROF_COUNT_W-1:0]                      count_t;
  typedef logic [`PROF_DATA_W-1:0]                       data_t;
  typedef logic [`PROF_ADDR_W-1:0]                       addr_t;
  typedef logic [`PROF_INSTR_W-1:0]                      instr_t;
  typedef logic [`PROF_STAT_IDX_W-1:0]                   stat_idx_t;
  typedef logic [`PROF_NUM_EVENTS-1:0]                   event_vec_t;
  typedef logic [`PROF_NUM_COUNTERS*`PROF_COUNT_W-1:0]   count_bus_t;

  typedef enum logic {
    SNAP_IDLE = 1'b0,
    SNAP_EMIT = 1'b1
  } snap_state_e;

endpackage

`default_nettype wire

// ==== include/core_prof_settings.svh ====
`ifndef CORE_PROF_SETTINGS_SVH
`define CORE_PROF_SETTINGS_SVH

// Datapath widths seen by the profiler.
`define PROF_COUNT_W      32
`define PROF_DATA_W       32
`define PROF_ADDR_W       32
`define PROF_INSTR_W      32
`define PROF_STAT_IDX_W   5

// Sixteen events plus the free-running cycle counter at index 0.
`define PROF_NUM_EVENTS   16
`define PROF_NUM_COUNTERS 17

`define PROF_EV_INSTR          0
`define PROF_EV_FADD           1
`define PROF_EV_FMUL           2
`define PROF_EV_LD             3
`define PROF_EV_ST             4
`define PROF_EV_BRANCH         5
`define PROF_EV_MISPREDICT     6
`define PROF_EV_ST_FP          7
`define PROF_EV_ST_DEPEND      8
`define PROF_EV_ST_IFETCH      9
`define PROF_EV_ST_LR_AQ       10
`define PROF_EV_ST_FENCE       11
`define PROF_EV_ST_MD          12
`define PROF_EV_ST_FORCE_WB    13
`define PROF_EV_ST_REMOTE_REQ  14
`define PROF_EV_ST_LOCAL_FLW   15

`define PROF_PRINT_STAT_ADDR   32'h0000_0D0C
`define PROF_JALR_OP           7'b1100111

`endif
